//--- include/imager_config.svh
`ifndef IMAGER_CONFIG_SVH
`define IMAGER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// imager build constants
////////////////////////////////////////////////////////////////////////////

// data path widths
`define IMAGER_BYTE_W       8     // one sensor byte
`define IMAGER_PIX_W        24    // three bytes per pixel word
`define IMAGER_PAT_W        10    // mask pattern toward the imager

// buffering
`define IMAGER_FRAME_WORDS  4     // small frame for this build
`define IMAGER_FRAME_DEPTH  16    // frame fifo words
`define IMAGER_PAT_DEPTH    8     // pattern fifo entries
`define IMAGER_FILL_W       ($clog2(`IMAGER_FRAME_DEPTH) + 1)

// host bus
`define IMAGER_ADDR_W       8
`define IMAGER_DATA_W       32

`endif

//--- src/imager_pkg.sv
`include "imager_config.svh"

package imager_pkg;

	////////////////////////////////////////////////////////////////////////////
	// codes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	// host register map, byte offsets
	typedef enum logic [`IMAGER_ADDR_W-1:0] {
		REG_CTRL    = 8'h00,    // bit 0 soft reset
		REG_STATUS  = 8'h04,    // frame flags
		REG_PIXEL   = 8'h08,    // pop one pixel word
		REG_PATTERN = 8'h0C,    // push one mask pattern
		REG_FILL    = 8'h10     // frame fifo level
	} reg_addr_e;

	typedef enum logic [1:0] {
		BYTE_HI,
		BYTE_MID,
		BYTE_LO
	} byte_phase_e;

	////////////////////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                      valid;
		logic [`IMAGER_BYTE_W-1:0] data;
	} sensor_byte_t;

	typedef struct packed {
		logic full;
		logic two_frames;
		logic one_frame;
	} frame_status_t;

	// master side of the lite bus
	typedef struct packed {
		logic                        aw_valid;
		logic [`IMAGER_ADDR_W-1:0]   aw_addr;
		logic                        w_valid;
		logic [`IMAGER_DATA_W-1:0]   w_data;
		logic [`IMAGER_DATA_W/8-1:0] w_strb;
		logic                        b_ready;
		logic                        ar_valid;
		logic [`IMAGER_ADDR_W-1:0]   ar_addr;
		logic                        r_ready;
	} axil_req_t;

	// slave side
	typedef struct packed {
		logic                      aw_ready;
		logic                      w_ready;
		logic                      b_valid;
		axi_resp_e                 b_resp;
		logic                      ar_ready;
		logic                      r_valid;
		logic [`IMAGER_DATA_W-1:0] r_data;
		axi_resp_e                 r_resp;
	} axil_rsp_t;

endpackage

//--- src/sync_fifo.sv
`include "imager_config.svh"

module sync_fifo
	import imager_pkg::*;
#(
	parameter int WIDTH       = `IMAGER_PIX_W,
	parameter int DEPTH       = `IMAGER_FRAME_DEPTH,
	parameter int FRAME_WORDS = `IMAGER_FRAME_WORDS
) (
	input  logic                   CLK_HS,
	input  logic                   clear,
	input  logic                   push,
	input  logic [WIDTH-1:0]       push_data,
	input  logic                   pop,
	output logic [WIDTH-1:0]       head,
	output logic                   empty,
	output logic                   full,
	output logic [$clog2(DEPTH):0] fill,
	output frame_status_t          status
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH) + 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wrap at DEPTH-1, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push = push && !full;     // overflow just drops the word
	assign do_pop  = pop && !empty;     // underflow ignored

	// storage, no reset on the array
	always_ff @(posedge CLK_HS) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK_HS) begin
		if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

	// fall-through head, flags follow count directly
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	assign fill  = count;

	assign status.full       = full;
	assign status.two_frames = (int'(count) >= 2 * FRAME_WORDS);
	assign status.one_frame  = (int'(count) >= FRAME_WORDS);

endmodule

//--- src/pixel_packer.sv
`include "imager_config.svh"

module pixel_packer
	import imager_pkg::*;
(
	input  logic                     CLK_HS,
	input  logic                     clear,
	input  sensor_byte_t             sensor,
	output logic [`IMAGER_PIX_W-1:0] word,
	output logic                     word_push
);

	localparam int B = `IMAGER_BYTE_W;

	byte_phase_e phase;     // which lane the next byte fills

	////////////////////////////////////////////////////////////////////////////
	// byte phase FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_HS) begin
		if (clear) begin
			phase     <= BYTE_HI;   // partial group is lost
			word_push <= 1'b0;
		end else begin
			word_push <= 1'b0;
			if (sensor.valid) begin
				case (phase)
					BYTE_HI:  phase <= BYTE_MID;
					BYTE_MID: phase <= BYTE_LO;
					default: begin
						phase     <= BYTE_HI;
						word_push <= 1'b1;  // third byte closes the word
					end
				endcase
			end
		end
	end

	// lane fill, first byte lands in the top lane
	always_ff @(posedge CLK_HS) begin
		if (sensor.valid) begin
			case (phase)
				BYTE_HI:  word[3*B-1 -: B] <= sensor.data;
				BYTE_MID: word[2*B-1 -: B] <= sensor.data;
				default:  word[B-1:0]      <= sensor.data;
			endcase
		end
	end

endmodule

//--- src/imager_regs.sv
`include "imager_config.svh"

module imager_regs
	import imager_pkg::*;
(
	input  logic                      CLK_HS,
	input  logic                      rst,
	input  axil_req_t                 axil_req,
	output axil_rsp_t                 axil_rsp,
	input  logic [`IMAGER_PIX_W-1:0]  pix_head,
	input  logic                      pix_empty,
	input  logic [`IMAGER_FILL_W-1:0] pix_fill,
	input  frame_status_t             pix_status,
	output logic                      pix_pop,
	input  logic                      pat_full,
	output logic                      pat_push,
	output logic [`IMAGER_PAT_W-1:0]  pat_data,
	output logic                      clear,
	output logic                      imager_rst_n
);

	localparam int DW = `IMAGER_DATA_W;

	logic          soft_rst;    // ctrl bit 0
	logic          b_valid;
	axi_resp_e     b_resp;
	logic          r_valid;
	axi_resp_e     r_resp;
	logic [DW-1:0] r_data;
	logic          wr_accept;
	logic          rd_accept;
	axi_resp_e     wr_resp;
	axi_resp_e     rd_resp;
	logic [DW-1:0] rd_data;

	// one outstanding response per direction
	assign wr_accept = axil_req.aw_valid && axil_req.w_valid && !b_valid;
	assign rd_accept = axil_req.ar_valid && !r_valid;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		wr_resp  = SLVERR;  // read-only and unmapped offsets
		pat_push = 1'b0;
		case (reg_addr_e'(axil_req.aw_addr))
			REG_CTRL: wr_resp = OKAY;
			REG_PATTERN: begin
				wr_resp  = pat_full ? SLVERR : OKAY;
				pat_push = wr_accept && !pat_full;  // full fifo stores nothing
			end
			default: wr_resp = SLVERR;
		endcase
	end

	assign pat_data = axil_req.w_data[`IMAGER_PAT_W-1:0];

	always_comb begin
		rd_resp = OKAY;
		rd_data = '0;
		pix_pop = 1'b0;
		case (reg_addr_e'(axil_req.ar_addr))
			REG_CTRL:   rd_data = {{(DW-1){1'b0}}, soft_rst};
			REG_STATUS: rd_data = {{(DW-3){1'b0}}, pix_status};
			REG_PIXEL: begin
				if (pix_empty) begin
					rd_resp = SLVERR;   // nothing to pop, data stays zero
				end else begin
					rd_data = {{(DW-`IMAGER_PIX_W){1'b0}}, pix_head};
					pix_pop = rd_accept;    // pop once, at ar acceptance
				end
			end
			REG_FILL: rd_data = {{(DW-`IMAGER_FILL_W){1'b0}}, pix_fill};
			default:  rd_resp = SLVERR; // pattern is write-only
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// response channels and ctrl
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_HS) begin
		if (rst) begin
			b_valid  <= 1'b0;
			r_valid  <= 1'b0;
			soft_rst <= 1'b0;
		end else begin
			if (wr_accept)
				b_valid <= 1'b1;
			else if (axil_req.b_ready)
				b_valid <= 1'b0;    // held until the host takes it
			if (rd_accept)
				r_valid <= 1'b1;
			else if (axil_req.r_ready)
				r_valid <= 1'b0;
			// only byte lane 0 carries the soft reset bit
			if (wr_accept && reg_addr_e'(axil_req.aw_addr) == REG_CTRL && axil_req.w_strb[0])
				soft_rst <= axil_req.w_data[0];
		end
	end

	// response payload
	always_ff @(posedge CLK_HS) begin
		if (wr_accept)
			b_resp <= wr_resp;
		if (rd_accept) begin
			r_resp <= rd_resp;
			r_data <= rd_data;
		end
	end

	always_comb begin
		axil_rsp.aw_ready = wr_accept;  // aw and w taken together
		axil_rsp.w_ready  = wr_accept;
		axil_rsp.b_valid  = b_valid;
		axil_rsp.b_resp   = b_resp;
		axil_rsp.ar_ready = rd_accept;
		axil_rsp.r_valid  = r_valid;
		axil_rsp.r_data   = r_data;
		axil_rsp.r_resp   = r_resp;
	end

	// host soft reset joins the board reset
	assign clear        = rst || soft_rst;
	assign imager_rst_n = !clear;

endmodule

//--- src/imager_top.sv
`include "imager_config.svh"

module imager_top
	import imager_pkg::*;
(
	input  logic                     CLK_HS,
	input  logic                     rst,
	input  sensor_byte_t             sensor,
	input  axil_req_t                axil_req,
	output axil_rsp_t                axil_rsp,
	input  logic                     stream,        // imager pops a pattern
	output logic [`IMAGER_PAT_W-1:0] mstream,
	output logic                     pattern_empty,
	output logic                     imager_rst_n
);

	logic [`IMAGER_PIX_W-1:0]  pix_word;
	logic                      pix_word_push;
	logic [`IMAGER_PIX_W-1:0]  pix_head;
	logic                      pix_empty;
	logic [`IMAGER_FILL_W-1:0] pix_fill;
	frame_status_t             pix_status;
	logic                      pix_pop;
	logic                      pat_full;
	logic                      pat_push;
	logic [`IMAGER_PAT_W-1:0]  pat_data;
	logic                      clear;       // rst or soft reset

	////////////////////////////////////////////////////////////////////////////
	// pixel path
	////////////////////////////////////////////////////////////////////////////

	pixel_packer u_packer (
		.CLK_HS    (CLK_HS),
		.clear     (clear),
		.sensor    (sensor),
		.word      (pix_word),
		.word_push (pix_word_push)
	);

	// sensor cannot stall, full is only reported through status
	sync_fifo #(
		.WIDTH       (`IMAGER_PIX_W),
		.DEPTH       (`IMAGER_FRAME_DEPTH),
		.FRAME_WORDS (`IMAGER_FRAME_WORDS)
	) u_frame_fifo (
		.CLK_HS    (CLK_HS),
		.clear     (clear),
		.push      (pix_word_push),
		.push_data (pix_word),
		.pop       (pix_pop),
		.head      (pix_head),
		.empty     (pix_empty),
		.full      (),
		.fill      (pix_fill),
		.status    (pix_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// host registers and pattern path
	////////////////////////////////////////////////////////////////////////////

	imager_regs u_regs (
		.CLK_HS       (CLK_HS),
		.rst          (rst),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.pix_head     (pix_head),
		.pix_empty    (pix_empty),
		.pix_fill     (pix_fill),
		.pix_status   (pix_status),
		.pix_pop      (pix_pop),
		.pat_full     (pat_full),
		.pat_push     (pat_push),
		.pat_data     (pat_data),
		.clear        (clear),
		.imager_rst_n (imager_rst_n)
	);

	// head drives mstream directly, pop on empty is ignored inside
	sync_fifo #(
		.WIDTH       (`IMAGER_PAT_W),
		.DEPTH       (`IMAGER_PAT_DEPTH),
		.FRAME_WORDS (`IMAGER_PAT_DEPTH / 2)
	) u_pattern_fifo (
		.CLK_HS    (CLK_HS),
		.clear     (clear),
		.push      (pat_push),
		.push_data (pat_data),
		.pop       (stream),
		.head      (mstream),
		.empty     (pattern_empty),
		.full      (pat_full),
		.fill      (),
		.status    ()
	);

endmodule

//--- verification/imager_assertions.sv
`include "imager_config.svh"

module imager_assertions
	import imager_pkg::*;
(
	input  logic                     CLK_HS,
	input  logic                     rst,
	input  axil_req_t                axil_req,
	input  axil_rsp_t                axil_rsp,
	input  logic                     pix_empty,
	input  frame_status_t            pix_status,
	input  logic                     stream,
	input  logic [`IMAGER_PAT_W-1:0] mstream,
	input  logic                     pattern_empty,
	input  logic                     imager_rst_n
);

	////////////////////////////////////////////////////////////////////////////
	// lite bus responses
	////////////////////////////////////////////////////////////////////////////

	b_held: assert property (@(posedge CLK_HS) disable iff (rst)
		axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
		else $error("b_valid dropped before b_ready");

	r_held: assert property (@(posedge CLK_HS) disable iff (rst)
		axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid)
		else $error("r_valid dropped before r_ready");

	// frame fifo level moves one step per edge, full and empty never meet
	frame_empty_step: assert property (@(posedge CLK_HS) disable iff (!imager_rst_n)
		pix_empty |=> !pix_status.full)
		else $error("frame fifo went from empty to full in one cycle");

	frame_full_step: assert property (@(posedge CLK_HS) disable iff (!imager_rst_n)
		pix_status.full |=> !pix_empty)
		else $error("frame fifo went from full to empty in one cycle");

	// head only moves on a pop or a clear
	pattern_hold: assert property (@(posedge CLK_HS) disable iff (!imager_rst_n)
		!pattern_empty && !stream |=> $stable(mstream))
		else $error("mstream changed without a stream pop");

endmodule

bind imager_top imager_assertions u_assertions (
	.CLK_HS        (CLK_HS),
	.rst           (rst),
	.axil_req      (axil_req),
	.axil_rsp      (axil_rsp),
	.pix_empty     (pix_empty),
	.pix_status    (pix_status),
	.stream        (stream),
	.mstream       (mstream),
	.pattern_empty (pattern_empty),
	.imager_rst_n  (imager_rst_n)
);

//--- verification/imager_tb.sv
`include "imager_config.svh"

module imager_tb
	import imager_pkg::*;
();

	typedef enum {
		STEP_WRITE,
		STEP_READ,
		STEP_BYTES,
		STEP_POP
	} step_kind_e;

	typedef struct {
		string       name;
		step_kind_e  kind;
		logic [7:0]  addr;
		logic [31:0] data;      // base value, +1 per repeat
		int          count;
		logic [31:0] exp_data;
		axi_resp_e   exp_resp;
	} step_t;

	logic                     CLK_HS;
	logic                     rst;
	sensor_byte_t             sensor;
	axil_req_t                axil_req;
	axil_rsp_t                axil_rsp;
	logic                     stream;
	logic [`IMAGER_PAT_W-1:0] mstream;
	logic                     pattern_empty;
	logic                     imager_rst_n;

	step_t                    steps[$];
	logic [`IMAGER_PIX_W-1:0] pix_model[$];    // words the frame fifo should hold
	logic [`IMAGER_PAT_W-1:0] pat_model[$];
	logic [7:0]               byte_buf[$];     // partial pixel group
	integer                   seed;
	int                       errors;
	int                       cycles;
	int                       limit;           // watchdog, 0 until the table is built

	imager_top UUT (
		.CLK_HS        (CLK_HS),
		.rst           (rst),
		.sensor        (sensor),
		.axil_req      (axil_req),
		.axil_rsp      (axil_rsp),
		.stream        (stream),
		.mstream       (mstream),
		.pattern_empty (pattern_empty),
		.imager_rst_n  (imager_rst_n)
	);

	initial begin
		CLK_HS = 1'b0;
		forever #50 CLK_HS = ~CLK_HS;
	end

	always @(posedge CLK_HS) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			fail_stop();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_stop();
		errors++;
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [`IMAGER_PIX_W-1:0] exp,
			input logic [`IMAGER_PIX_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (exp !== act) begin
			$display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
			fail_stop();
		end
	endtask

	task automatic check_status(input string name, input frame_status_t exp,
			input frame_status_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_pattern(input string name, input logic [`IMAGER_PAT_W-1:0] exp,
			input logic [`IMAGER_PAT_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_fill(input string name, input logic [`IMAGER_FILL_W-1:0] exp,
			input logic [`IMAGER_FILL_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			fail_stop();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus and sensor drivers, all start and end on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic axi_write(input string name, input logic [7:0] addr,
			input logic [31:0] data, output axi_resp_e resp);
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr  = addr;
		axil_req.w_valid  = 1'b1;
		axil_req.w_data   = data;
		axil_req.w_strb   = '1;
		axil_req.b_ready  = 1'b0;   // response stalled for a cycle
		@(posedge CLK_HS);          // acceptance edge, no response pending
		check_flag({name, " aw_ready"}, 1'b1, axil_rsp.aw_ready);
		check_flag({name, " w_ready"}, 1'b1, axil_rsp.w_ready);
		do @(negedge CLK_HS); while (!axil_rsp.b_valid);
		resp              = axil_rsp.b_resp;
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid  = 1'b0;
		@(negedge CLK_HS);
		axil_req.b_ready  = 1'b1;
		@(negedge CLK_HS);
		axil_req.b_ready  = 1'b0;
	endtask

	task automatic axi_read(input string name, input logic [7:0] addr,
			output logic [31:0] data, output axi_resp_e resp);
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr  = addr;
		axil_req.r_ready  = 1'b0;   // stall, the pop must still happen once
		@(posedge CLK_HS);
		check_flag({name, " ar_ready"}, 1'b1, axil_rsp.ar_ready);
		do @(negedge CLK_HS); while (!axil_rsp.r_valid);
		data              = axil_rsp.r_data;
		resp              = axil_rsp.r_resp;
		axil_req.ar_valid = 1'b0;
		@(negedge CLK_HS);
		axil_req.r_ready  = 1'b1;
		@(negedge CLK_HS);
		axil_req.r_ready  = 1'b0;
	endtask

	// packing rule, first byte of a group on top
	task automatic model_byte(input logic [7:0] b);
		byte_buf.push_back(b);
		if (byte_buf.size() == 3) begin
			if (pix_model.size() < `IMAGER_FRAME_DEPTH)
				pix_model.push_back({byte_buf[0], byte_buf[1], byte_buf[2]});
			byte_buf.delete();  // overflow word is lost
		end
	endtask

	task automatic send_bytes(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r            = $random(seed);
			sensor.valid = 1'b1;
			sensor.data  = r[7:0];
			model_byte(r[7:0]);
			@(negedge CLK_HS);
		end
		sensor.valid = 1'b0;
		@(negedge CLK_HS);  // last word enters the fifo
		@(negedge CLK_HS);  // idle, status current
	endtask

	////////////////////////////////////////////////////////////////////////////
	// table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_step(input string name, input step_kind_e kind, input logic [7:0] addr,
			input logic [31:0] data, input int count, input logic [31:0] exp_data,
			input axi_resp_e exp_resp);
		step_t s;
		s.name     = name;
		s.kind     = kind;
		s.addr     = addr;
		s.data     = data;
		s.count    = count;
		s.exp_data = exp_data;
		s.exp_resp = exp_resp;
		steps.push_back(s);
	endtask

	function automatic int step_cost(input step_t s);
		case (s.kind)
			STEP_BYTES: return s.count + 3;
			STEP_POP:   return 2 * s.count + 2;
			default:    return 4 * s.count;   // one bus transfer each
		endcase
	endfunction

	task automatic run_step(input step_t st);
		logic [31:0]              data;
		logic [31:0]              rdata;
		logic [`IMAGER_PIX_W-1:0] exp_word;
		axi_resp_e                resp;
		case (st.kind)
			STEP_WRITE: begin
				for (int i = 0; i < st.count; i++) begin
					data = st.data + i;
					axi_write(st.name, st.addr, data, resp);
					check_resp(st.name, st.exp_resp, resp);
					if (st.exp_resp == OKAY && st.addr == REG_PATTERN)
						pat_model.push_back(data[`IMAGER_PAT_W-1:0]);
					if (st.addr == REG_CTRL) begin
						if (data[0]) begin
							pix_model.delete();     // soft reset empties both fifos
							pat_model.delete();
							byte_buf.delete();
						end
						check_flag({st.name, " imager_rst_n"}, !data[0], imager_rst_n);
					end
				end
			end
			STEP_READ: begin
				for (int i = 0; i < st.count; i++) begin
					axi_read(st.name, st.addr, rdata, resp);
					check_resp(st.name, st.exp_resp, resp);
					case (st.addr)
						REG_PIXEL: begin
							exp_word = st.exp_data[`IMAGER_PIX_W-1:0];
							if (st.exp_resp == OKAY)
								exp_word = pix_model.pop_front();
							check_word(st.name, exp_word, rdata[`IMAGER_PIX_W-1:0]);
						end
						REG_STATUS: check_status(st.name, frame_status_t'(st.exp_data[2:0]),
							frame_status_t'(rdata[2:0]));
						REG_FILL: check_fill(st.name, st.exp_data[`IMAGER_FILL_W-1:0],
							rdata[`IMAGER_FILL_W-1:0]);
						REG_CTRL: check_flag(st.name, st.exp_data[0], rdata[0]);
						default:  check_word(st.name, st.exp_data[`IMAGER_PIX_W-1:0],
							rdata[`IMAGER_PIX_W-1:0]);
					endcase
				end
			end
			STEP_BYTES: send_bytes(st.count);
			default: begin
				for (int i = 0; i < st.count; i++) begin
					check_flag({st.name, " not empty"}, 1'b0, pattern_empty);
					check_pattern(st.name, pat_model.pop_front(), mstream);
					stream = 1'b1;
					@(negedge CLK_HS);
					stream = 1'b0;
				end
				check_flag({st.name, " empty"}, 1'b1, pattern_empty);
			end
		endcase
	endtask

	initial begin
		int budget;
		rst      = 1'b1;
		sensor   = '0;
		axil_req = '0;
		stream   = 1'b0;
		seed     = 32'h3484f30d;
		errors   = 0;
		cycles   = 0;
		limit    = 0;

		// packing order, then an empty pop
		add_step("pack bytes", STEP_BYTES, 8'h00, 0, 9, 0, OKAY);
		add_step("pack read", STEP_READ, REG_PIXEL, 0, 3, 0, OKAY);
		add_step("empty pop", STEP_READ, REG_PIXEL, 0, 1, 0, SLVERR);
		// frame flags at 4 and 8 words
		add_step("frame one bytes", STEP_BYTES, 8'h00, 0, 12, 0, OKAY);
		add_step("one frame", STEP_READ, REG_STATUS, 0, 1, 32'h1, OKAY);
		add_step("frame two bytes", STEP_BYTES, 8'h00, 0, 12, 0, OKAY);
		add_step("two frames", STEP_READ, REG_STATUS, 0, 1, 32'h3, OKAY);
		add_step("fill eight", STEP_READ, REG_FILL, 0, 1, 8, OKAY);
		add_step("frame drain", STEP_READ, REG_PIXEL, 0, 8, 0, OKAY);
		add_step("drained status", STEP_READ, REG_STATUS, 0, 1, 0, OKAY);
		// 17 words into 16 places
		add_step("overflow bytes", STEP_BYTES, 8'h00, 0, 51, 0, OKAY);
		add_step("overflow status", STEP_READ, REG_STATUS, 0, 1, 32'h7, OKAY);
		add_step("overflow fill", STEP_READ, REG_FILL, 0, 1, 16, OKAY);
		add_step("overflow drain", STEP_READ, REG_PIXEL, 0, 16, 0, OKAY);
		add_step("overflow empty", STEP_READ, REG_PIXEL, 0, 1, 0, SLVERR);
		add_step("unmapped read", STEP_READ, 8'h14, 0, 1, 0, SLVERR);
		add_step("status write", STEP_WRITE, REG_STATUS, 0, 1, 0, SLVERR);
		// pattern fifo
		add_step("pattern push", STEP_WRITE, REG_PATTERN, 32'h2a5, 8, 0, OKAY);
		add_step("pattern full", STEP_WRITE, REG_PATTERN, 32'h155, 1, 0, SLVERR);
		add_step("pattern pop", STEP_POP, 8'h00, 0, 8, 0, OKAY);
		// soft reset with data in both fifos
		add_step("pre reset bytes", STEP_BYTES, 8'h00, 0, 6, 0, OKAY);
		add_step("pre reset pattern", STEP_WRITE, REG_PATTERN, 32'h0f0, 2, 0, OKAY);
		add_step("soft reset on", STEP_WRITE, REG_CTRL, 32'h1, 1, 0, OKAY);
		add_step("reset status", STEP_READ, REG_STATUS, 0, 1, 0, OKAY);
		add_step("reset fill", STEP_READ, REG_FILL, 0, 1, 0, OKAY);
		add_step("reset ctrl", STEP_READ, REG_CTRL, 0, 1, 32'h1, OKAY);
		add_step("reset patterns", STEP_POP, 8'h00, 0, 0, 0, OKAY);
		add_step("soft reset off", STEP_WRITE, REG_CTRL, 32'h0, 1, 0, OKAY);
		add_step("after reset bytes", STEP_BYTES, 8'h00, 0, 3, 0, OKAY);
		add_step("after reset read", STEP_READ, REG_PIXEL, 0, 1, 0, OKAY);

		budget = 10;    // reset and settling
		foreach (steps[k])
			budget += step_cost(steps[k]);
		limit = 2 * budget;

		@(negedge CLK_HS);
		check_flag("reset imager_rst_n", 1'b0, imager_rst_n);
		repeat (3) @(negedge CLK_HS);
		rst = 1'b0;     // after the fourth rising edge
		check_flag("reset pattern_empty", 1'b1, pattern_empty);
		check_flag("reset b_valid", 1'b0, axil_rsp.b_valid);
		check_flag("reset r_valid", 1'b0, axil_rsp.r_valid);
		@(negedge CLK_HS);

		foreach (steps[k])
			run_step(steps[k]);

		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			fail_stop();
		end
	end

endmodule

//--- sources.f
+incdir+include
src/imager_pkg.sv
src/sync_fifo.sv
src/pixel_packer.sv
src/imager_regs.sv
src/imager_top.sv
verification/imager_assertions.sv
verification/imager_tb.sv

//--- Makefile
# Verilator flow for the imager readout core

TOP := imager_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

# the run may stop on $fatal, the log search decides the result
sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
